/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - rtl/decode_pkg.sv
      - rtl/opcode_decoder.sv
      - rtl/funct_decoder.sv
      - rtl/decode_merge.sv
      - rtl/decode_stage.sv
  - target: simulation
    files:
      - verif/decode_tb.sv

/* rtl/decode_merge.sv */
`timescale 1ns/1ps

module decode_merge (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  logic                     is_special,
    input  decode_pkg::unit_result_t op_res,
    input  decode_pkg::unit_result_t fn_res,
    output decode_pkg::decode_out_t  decoded
);
    import decode_pkg::*;

    unit_result_t sel;
    decode_out_t  nxt;

    assign sel = is_special ? fn_res : op_res;

    always_comb begin
        nxt = '0;
        if (instr_valid) begin
            nxt.valid = 1'b1;
            if (!sel.hit) begin
                nxt.reserved = 1'b1;
            end else begin
                nxt.ctl  = sel.ctl;
                nxt.regs = sel.regs;
                // writes to r0 are dropped, dest is kept
                if (sel.regs.dest == '0) begin
                    nxt.ctl.regwrite = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decoded <= '0;
        end else begin
            decoded <= nxt;
        end
    end

    a_reserved_inert: assert property (@(posedge clk) disable iff (!rst_n)
        decoded.reserved |-> !(decoded.ctl.regwrite || decoded.ctl.memwrite ||
                               decoded.ctl.branch || decoded.ctl.jump));

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        decoded.ctl.regwrite |-> (decoded.regs.dest != '0));

    a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        !instr_valid |=> !decoded.valid);

endmodule

/* rtl/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_func_t;
    typedef logic [2:0]  branch_type_t;
    typedef logic [1:0]  msize_t;

    // zero passes srca through untouched, no arithmetic
    localparam alu_func_t ALU_PASSA = 4'd0;
    localparam alu_func_t ALU_ADD   = 4'd1;
    localparam alu_func_t ALU_ADDU  = 4'd2;
    localparam alu_func_t ALU_SUB   = 4'd3;
    localparam alu_func_t ALU_SUBU  = 4'd4;
    localparam alu_func_t ALU_SLT   = 4'd5;
    localparam alu_func_t ALU_SLTU  = 4'd6;
    localparam alu_func_t ALU_AND   = 4'd7;
    localparam alu_func_t ALU_OR    = 4'd8;
    localparam alu_func_t ALU_XOR   = 4'd9;
    localparam alu_func_t ALU_NOR   = 4'd10;
    localparam alu_func_t ALU_SLL   = 4'd11;
    localparam alu_func_t ALU_SRL   = 4'd12;
    localparam alu_func_t ALU_SRA   = 4'd13;
    localparam alu_func_t ALU_LUI   = 4'd14;
    localparam alu_func_t ALU_PASSB = 4'd15;

    localparam branch_type_t BR_BEQ  = 3'd1;
    localparam branch_type_t BR_BNE  = 3'd2;
    localparam branch_type_t BR_BGEZ = 3'd3;
    localparam branch_type_t BR_BLTZ = 3'd4;
    localparam branch_type_t BR_BGTZ = 3'd5;
    localparam branch_type_t BR_BLEZ = 3'd6;

    localparam msize_t MSIZE_NONE = 2'd0;
    localparam msize_t MSIZE_BYTE = 2'd1;
    localparam msize_t MSIZE_HALF = 2'd2;
    localparam msize_t MSIZE_WORD = 2'd3;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LB      = 6'b100000;
    localparam opcode_t OP_LH      = 6'b100001;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_LBU     = 6'b100100;
    localparam opcode_t OP_LHU     = 6'b100101;
    localparam opcode_t OP_SB      = 6'b101000;
    localparam opcode_t OP_SH      = 6'b101001;
    localparam opcode_t OP_SW      = 6'b101011;

    // regimm rt field
    localparam reg_addr_t RT_BLTZ   = 5'b00000;
    localparam reg_addr_t RT_BGEZ   = 5'b00001;
    localparam reg_addr_t RT_BLTZAL = 5'b10000;
    localparam reg_addr_t RT_BGEZAL = 5'b10001;

    // special function field
    localparam funct_t F_SLL   = 6'b000000;
    localparam funct_t F_SRL   = 6'b000010;
    localparam funct_t F_SRA   = 6'b000011;
    localparam funct_t F_SLLV  = 6'b000100;
    localparam funct_t F_SRLV  = 6'b000110;
    localparam funct_t F_SRAV  = 6'b000111;
    localparam funct_t F_JR    = 6'b001000;
    localparam funct_t F_JALR  = 6'b001001;
    localparam funct_t F_MFHI  = 6'b010000;
    localparam funct_t F_MTHI  = 6'b010001;
    localparam funct_t F_MFLO  = 6'b010010;
    localparam funct_t F_MTLO  = 6'b010011;
    localparam funct_t F_MULT  = 6'b011000;
    localparam funct_t F_MULTU = 6'b011001;
    localparam funct_t F_DIV   = 6'b011010;
    localparam funct_t F_DIVU  = 6'b011011;
    localparam funct_t F_ADD   = 6'b100000;
    localparam funct_t F_ADDU  = 6'b100001;
    localparam funct_t F_SUB   = 6'b100010;
    localparam funct_t F_SUBU  = 6'b100011;
    localparam funct_t F_AND   = 6'b100100;
    localparam funct_t F_OR    = 6'b100101;
    localparam funct_t F_XOR   = 6'b100110;
    localparam funct_t F_NOR   = 6'b100111;
    localparam funct_t F_SLT   = 6'b101010;
    localparam funct_t F_SLTU  = 6'b101011;

    localparam reg_addr_t LINK_REG = 5'd31;

    // field order is fixed, the pattern file depends on it
    typedef struct packed {
        alu_func_t    alufunc;
        logic         alusrc_imm;
        logic         zeroext;
        logic         shamt_valid;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        msize_t       msize;
        logic         memsext;
        branch_type_t branch_type;
        logic         branch;
        logic         jump;
        logic         jr;
        logic         is_link;
        logic         hiwrite;
        logic         lowrite;
        logic         hitoreg;
        logic         lotoreg;
    } decode_ctl_t;

    typedef struct packed {
        reg_addr_t srca;
        reg_addr_t srcb;
        reg_addr_t dest;
    } reg_sel_t;

    typedef struct packed {
        decode_ctl_t ctl;
        reg_sel_t    regs;
        logic        hit;
    } unit_result_t;

    typedef struct packed {
        logic        valid;
        logic        reserved;
        decode_ctl_t ctl;
        reg_sel_t    regs;
    } decode_out_t;

endpackage

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  decode_pkg::word_t       instr,
    input  logic                    instr_valid,
    output decode_pkg::decode_out_t decoded
);
    import decode_pkg::*;

    unit_result_t op_res;
    unit_result_t fn_res;
    logic         is_special;

    // both decoders look at the same word in parallel
    opcode_decoder u_opcode_decoder (
        .instr      (instr),
        .op_res     (op_res),
        .is_special (is_special)
    );

    funct_decoder u_funct_decoder (
        .instr  (instr),
        .fn_res (fn_res)
    );

    decode_merge u_decode_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .is_special  (is_special),
        .op_res      (op_res),
        .fn_res      (fn_res),
        .decoded     (decoded)
    );

endmodule

/* rtl/funct_decoder.sv */
`timescale 1ns/1ps

module funct_decoder (
    input  decode_pkg::word_t        instr,
    output decode_pkg::unit_result_t fn_res
);
    import decode_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    funct_t    funct;

    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];
    assign funct = instr[5:0];

    function automatic alu_func_t rtype_alu(input funct_t f);
        case (f)
            F_ADD:                return ALU_ADD;
            F_ADDU:               return ALU_ADDU;
            F_SUB:                return ALU_SUB;
            F_SUBU:               return ALU_SUBU;
            F_SLT:                return ALU_SLT;
            F_SLTU:               return ALU_SLTU;
            F_AND:                return ALU_AND;
            F_OR:                 return ALU_OR;
            F_XOR:                return ALU_XOR;
            F_NOR:                return ALU_NOR;
            F_SLL, F_SLLV:        return ALU_SLL;
            F_SRL, F_SRLV:        return ALU_SRL;
            F_SRA, F_SRAV:        return ALU_SRA;
            default:              return ALU_PASSA;
        endcase
    endfunction

    always_comb begin
        fn_res = '0;
        fn_res.hit = 1'b1;
        case (funct)
            F_ADD, F_ADDU, F_SUB, F_SUBU, F_SLT, F_SLTU,
            F_AND, F_OR, F_XOR, F_NOR, F_SLLV, F_SRLV, F_SRAV: begin
                fn_res.ctl.alufunc  = rtype_alu(funct);
                fn_res.ctl.regwrite = 1'b1;
                fn_res.regs         = '{srca: rs, srcb: rt, dest: rd};
            end
            F_SLL, F_SRL, F_SRA: begin
                // shift amount comes from the shamt field
                fn_res.ctl.alufunc     = rtype_alu(funct);
                fn_res.ctl.regwrite    = 1'b1;
                fn_res.ctl.shamt_valid = 1'b1;
                fn_res.regs            = '{srca: '0, srcb: rt, dest: rd};
            end
            F_JR, F_JALR: begin
                fn_res.ctl.jump     = 1'b1;
                fn_res.ctl.jr       = 1'b1;
                fn_res.ctl.regwrite = (funct == F_JALR);
                fn_res.ctl.is_link  = (funct == F_JALR);
                fn_res.regs.srca    = rs;
                fn_res.regs.dest    = (funct == F_JALR) ? rd : reg_addr_t'(0);
            end
            F_MULT, F_MULTU, F_DIV, F_DIVU: begin
                fn_res.ctl.hiwrite = 1'b1;
                fn_res.ctl.lowrite = 1'b1;
                fn_res.regs.srca   = rs;
                fn_res.regs.srcb   = rt;
            end
            F_MFHI, F_MFLO: begin
                fn_res.ctl.alufunc  = (funct == F_MFHI) ? ALU_PASSA : ALU_PASSB;
                fn_res.ctl.regwrite = 1'b1;
                fn_res.ctl.hitoreg  = (funct == F_MFHI);
                fn_res.ctl.lotoreg  = (funct == F_MFLO);
                fn_res.regs.dest    = rd;
            end
            F_MTHI, F_MTLO: begin
                fn_res.ctl.alufunc = ALU_PASSA;
                fn_res.ctl.hiwrite = (funct == F_MTHI);
                fn_res.ctl.lowrite = (funct == F_MTLO);
                fn_res.regs.srca   = rs;
            end
            default: fn_res.hit = 1'b0;
        endcase
    end

endmodule

/* rtl/opcode_decoder.sv */
`timescale 1ns/1ps

module opcode_decoder (
    input  decode_pkg::word_t        instr,
    output decode_pkg::unit_result_t op_res,
    output logic                     is_special
);
    import decode_pkg::*;

    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    assign is_special = (opcode == OP_SPECIAL);

    function automatic alu_func_t imm_alu(input opcode_t op);
        case (op)
            OP_ADDI:  return ALU_ADD;
            OP_ADDIU: return ALU_ADDU;
            OP_SLTI:  return ALU_SLT;
            OP_SLTIU: return ALU_SLTU;
            OP_ANDI:  return ALU_AND;
            OP_ORI:   return ALU_OR;
            OP_XORI:  return ALU_XOR;
            OP_LUI:   return ALU_LUI;
            default:  return ALU_PASSA;
        endcase
    endfunction

    always_comb begin
        op_res = '0;
        op_res.hit = 1'b1;
        case (opcode)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                op_res.ctl.alufunc    = imm_alu(opcode);
                op_res.ctl.alusrc_imm = 1'b1;
                op_res.ctl.regwrite   = 1'b1;
                op_res.ctl.zeroext    = (opcode inside {OP_ANDI, OP_ORI, OP_XORI});
                // lui ignores rs
                op_res.regs.srca = (opcode == OP_LUI) ? reg_addr_t'(0) : rs;
                op_res.regs.dest = rt;
            end
            OP_REGIMM: begin
                op_res.ctl.branch = 1'b1;
                op_res.regs.srca  = rs;
                case (rt)
                    RT_BGEZ:  op_res.ctl.branch_type = BR_BGEZ;
                    RT_BLTZ:  op_res.ctl.branch_type = BR_BLTZ;
                    RT_BGEZAL, RT_BLTZAL: begin
                        op_res.ctl.branch_type = (rt == RT_BGEZAL) ? BR_BGEZ : BR_BLTZ;
                        op_res.ctl.regwrite    = 1'b1;
                        op_res.ctl.is_link     = 1'b1;
                        op_res.regs.dest       = LINK_REG;
                    end
                    default:  op_res.hit = 1'b0;
                endcase
            end
            OP_BEQ, OP_BNE: begin
                op_res.ctl.branch      = 1'b1;
                op_res.ctl.branch_type = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                op_res.regs.srca       = rs;
                op_res.regs.srcb       = rt;
            end
            OP_BGTZ, OP_BLEZ: begin
                op_res.ctl.branch      = 1'b1;
                op_res.ctl.branch_type = (opcode == OP_BGTZ) ? BR_BGTZ : BR_BLEZ;
                op_res.regs.srca       = rs;
            end
            OP_J: begin
                op_res.ctl.jump = 1'b1;
            end
            OP_JAL: begin
                op_res.ctl.jump     = 1'b1;
                op_res.ctl.regwrite = 1'b1;
                op_res.ctl.is_link  = 1'b1;
                op_res.regs.dest    = LINK_REG;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                // address is rs plus offset
                op_res.ctl.alufunc    = ALU_ADDU;
                op_res.ctl.alusrc_imm = 1'b1;
                op_res.ctl.regwrite   = 1'b1;
                op_res.ctl.memtoreg   = 1'b1;
                op_res.ctl.memsext    = (opcode inside {OP_LB, OP_LH});
                op_res.ctl.msize      = (opcode inside {OP_LB, OP_LBU}) ? MSIZE_BYTE :
                                        (opcode inside {OP_LH, OP_LHU}) ? MSIZE_HALF :
                                                                          MSIZE_WORD;
                op_res.regs.srca      = rs;
                op_res.regs.dest      = rt;
            end
            OP_SB, OP_SH, OP_SW: begin
                op_res.ctl.alufunc    = ALU_ADDU;
                op_res.ctl.alusrc_imm = 1'b1;
                op_res.ctl.memwrite   = 1'b1;
                op_res.ctl.msize      = (opcode == OP_SB) ? MSIZE_BYTE :
                                        (opcode == OP_SH) ? MSIZE_HALF : MSIZE_WORD;
                op_res.regs.srca      = rs;
                op_res.regs.srcb      = rt;
            end
            // special lands here too, merge takes funct_decoder then
            default: op_res.hit = 1'b0;
        endcase
    end

endmodule

/* sources.f */
rtl/decode_pkg.sv
rtl/opcode_decoder.sv
rtl/funct_decoder.sv
rtl/decode_merge.sv
rtl/decode_stage.sv
verif/decode_tb.sv

/* verif/decode_patterns.hex */
// columns: behavior id, instr_valid, instruction word, expected decode_out_t (12 hex digits)
// ids: 1 imm alu, 2 reg alu and shifts, 3 control flow, 4 memory and hi/lo, 5 reserved, 6 r0 and bubbles
1 1 20220005 010C80000402  // addi
1 1 24220005 011480000402  // addiu
1 1 28220005 012C80000402  // slti
1 1 2C220005 013480000402  // sltiu
1 1 30220005 013E80000402  // andi
1 1 34220005 014680000402  // ori
1 1 38220005 014E80000402  // xori
1 1 3C221234 017480000002  // lui, rs ignored
2 1 00221820 010880000443  // add
2 1 00221821 011080000443  // addu
2 1 00221822 011880000443  // sub
2 1 00221823 012080000443  // subu
2 1 00221824 013880000443  // and
2 1 00221825 014080000443  // or
2 1 00221826 014880000443  // xor
2 1 00221827 015080000443  // nor
2 1 0022182A 012880000443  // slt
2 1 0022182B 013080000443  // sltu
2 1 00021900 015980000043  // sll
2 1 00021902 016180000043  // srl
2 1 00221903 016980000043  // sra with rs set
2 1 00221804 015880000443  // sllv
2 1 00221806 016080000443  // srlv
2 1 00221807 016880000443  // srav
3 1 10220010 010000C00440  // beq
3 1 14220010 010001400440  // bne
3 1 18200010 010003400400  // blez
3 1 1C200010 010002C00400  // bgtz
3 1 04200010 010002400400  // bltz
3 1 04210010 010001C00400  // bgez
3 1 04300010 01008248041F  // bltzal
3 1 04310010 010081C8041F  // bgezal
3 1 08000100 010000200000  // j
3 1 0C000100 01008028001F  // jal
3 1 00200008 010000300400  // jr
3 1 0020F809 01008038041F  // jalr
4 1 80220004 0114CC000402  // lb
4 1 84220004 0114D4000402  // lh
4 1 8C220004 0114D8000402  // lw
4 1 90220004 0114C8000402  // lbu
4 1 94220004 0114D0000402  // lhu
4 1 A0220004 011428000440  // sb
4 1 A4220004 011430000440  // sh
4 1 AC220004 011438000440  // sw
4 1 00220018 010000060440  // mult
4 1 00220019 010000060440  // multu
4 1 0022001A 010000060440  // div
4 1 0022001B 010000060440  // divu
4 1 00001810 010080010003  // mfhi
4 1 00001812 017880008003  // mflo
4 1 00200011 010000040400  // mthi
4 1 00200013 010000020400  // mtlo
5 1 FC221800 018000000000  // unknown opcode
5 1 00221801 018000000000  // unknown function code
5 1 04220010 018000000000  // unknown regimm rt
5 1 40026000 018000000000  // mfc0
5 1 70221802 018000000000  // special2 mul
6 1 24200005 011400000400  // addiu to r0
6 1 00220020 010800000440  // add to r0
6 0 00221820 000000000000  // bubble
6 0 FC000000 000000000000  // bubble over a reserved word
6 1 00000000 015900000000  // nop

/* verif/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;
    import decode_pkg::*;

    localparam int NUM_ROWS   = 62;
    localparam int RESET_CYC  = 16;
    localparam int MAX_CYCLES = RESET_CYC + NUM_ROWS + 20;

    logic        clk;
    logic        rst_n;
    word_t       instr;
    logic        instr_valid;
    decode_out_t decoded;

    // four words per row: behavior id, valid, instruction, expected bundle
    logic [47:0] pat [0:NUM_ROWS*4-1];

    int cycle_cnt;

    decode_stage dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .decoded     (decoded)
    );

    always #10 clk = ~clk;

    function automatic string behavior_name(input logic [47:0] id);
        case (id)
            48'd1:   return "imm_alu";
            48'd2:   return "reg_alu_shift";
            48'd3:   return "control_flow";
            48'd4:   return "mem_hilo";
            48'd5:   return "reserved";
            48'd6:   return "r0_bubble";
            default: return "unknown";
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    // watchdog sized from reset length and row count
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, run still going after %0d cycles", cycle_cnt);
            stop_with_failure("timeout");
        end
    end

    initial begin
        int          row;
        logic [47:0] expected;
        logic [47:0] actual;

        clk         = 1'b0;
        rst_n       = 1'b0;
        // valid addi held through reset so only the reset clears the output
        instr       = 32'h2022_0005;
        instr_valid = 1'b1;
        cycle_cnt   = 0;

        $readmemh("verif/decode_patterns.hex", pat);
        assert (!$isunknown(pat[NUM_ROWS*4-1])) else begin
            $display("pattern file is missing or shorter than %0d rows", NUM_ROWS);
            stop_with_failure("pattern file load");
        end

        repeat (RESET_CYC) @(posedge clk);
        rst_n       <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;

        @(negedge clk);
        assert (decoded == '0) else begin
            $display("decoded output is not all zeros after reset");
            stop_with_failure("reset value");
        end

        // row i is driven on the edge where row i-1 reaches the output
        for (row = 0; row <= NUM_ROWS; row++) begin
            @(posedge clk);
            if (row < NUM_ROWS) begin
                instr_valid <= pat[row*4+1][0];
                instr       <= pat[row*4+2][31:0];
            end else begin
                instr_valid <= 1'b0;
                instr       <= '0;
            end
            if (row > 0) begin
                @(negedge clk);
                expected = pat[(row-1)*4+3];
                actual   = 48'(decoded);
                assert (actual == expected) else begin
                    $display("ERR %s row %0d expected %h actual %h",
                             behavior_name(pat[(row-1)*4]), row - 1, expected, actual);
                    stop_with_failure("decoded bundle mismatch");
                end
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule
